// ==== input_pkg.sv ====
package input_pkg;

    // raw board joystick, bits 3:0 are right, left, down, up
    typedef logic [15:0] board_joy_t;

    // game joystick word, same layout as the low board bits
    typedef logic [9:0] joy_t;

    typedef logic [3:0] coin_t;        // one bit per player slot
    typedef logic signed [8:0] mouse_delta_t;
    typedef logic [7:0] pos_t;
    typedef logic [2:0] mouse_but_t;

    // outputs are active low towards the game
    localparam bit ACTIVE_LOW = 1'b1;

    localparam int BUTTONS = 2;

    // bit positions above the fire buttons
    localparam int START_BIT = 4 + BUTTONS;
    localparam int COIN_BIT  = 5 + BUTTONS;
    localparam int PAUSE_BIT = 6 + BUTTONS;

    // autofire opens once the frame counter passes this value
    localparam int AUTOFIRE_DIV = 5;

    typedef enum logic [1:0] {
        run,
        paused,
        step_frame     // runs one frame, then back to paused
    } pause_state_e;

endpackage

// ==== mouse_if.sv ====
`timescale 1ns/100ps

interface mouse_if import input_pkg::*; ();

    mouse_delta_t dx;
    mouse_delta_t dy;
    logic [7:0]   flags;   // buttons in 2:0
    logic         st;      // one cycle per report
    logic         idx;     // 0 for player 1, 1 for player 2

    modport src (
        output dx, dy, flags, st, idx
    );

    modport sink (
        input dx, dy, flags, st, idx
    );

endinterface

// ==== four_way_joy.sv ====
`timescale 1ns/100ps

module four_way_joy (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic [3:0] joy8way,
    output logic [3:0] joy4way
);

    logic [3:0] last_dir;  // last single direction seen
    logic       single;
    logic       idle;

    // exactly one direction pressed
    always_comb begin
        single = 1'b0;
        case (joy8way)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: single = 1'b1;
            default: single = 1'b0;
        endcase
    end

    assign idle = (joy8way == 4'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_dir <= '0;
            joy4way  <= '0;
        end else if (!enable || idle) begin
            joy4way <= joy8way;   // filter off or stick released
        end else if (single) begin
            last_dir <= joy8way;
            joy4way  <= joy8way;
        end else begin
            // diagonal, keep going the way we were
            joy4way <= last_dir;
        end
    end

endmodule

// ==== joy_mapper.sv ====
`timescale 1ns/100ps

module joy_mapper import input_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  board_joy_t board,
    input  logic [3:0] dir4,
    input  joy_t       key,
    input  mouse_but_t mouse_but,
    input  logic       rot,
    input  logic       flip,
    input  logic       autofire,
    input  logic       lock,
    output joy_t       joy,
    output logic       joy_pause_raw
);

    logic [9:4] board_btn_q;  // aligned with the 4-way filter register
    joy_t       key_q;
    joy_t       merged;
    joy_t       rotated;

    always_ff @(posedge clk) begin
        board_btn_q <= board[9:4];
        key_q       <= key;
    end

    // everything active high at this point
    assign merged = {board_btn_q, dir4} | key_q | {3'd0, mouse_but, 4'd0};

    assign joy_pause_raw = merged[PAUSE_BIT];

    always_comb begin
        rotated    = merged;
        rotated[4] = merged[4] & autofire;  // first fire button only
        if (rot) begin
            if (flip) begin
                rotated[3:0] = {merged[1], merged[0], merged[2], merged[3]};
            end else begin
                rotated[3:0] = {merged[0], merged[1], merged[3], merged[2]};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joy <= {10{ACTIVE_LOW}};
        end else if (lock) begin
            joy <= {10{ACTIVE_LOW}};   // all released
        end else begin
            joy <= rotated ^ {10{ACTIVE_LOW}};
        end
    end

endmodule

// ==== paddle_accum.sv ====
`timescale 1ns/100ps

module paddle_accum import input_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    mouse_if.sink mouse,
    output pos_t  paddle
);

    pos_t step;

    // only the low byte of the horizontal motion matters
    assign step = mouse.dx[7:0];

    // both players' reports move the same paddle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            paddle <= '0;
        end else if (mouse.st) begin
            paddle <= paddle + step;   // wraps around
        end
    end

endmodule

// ==== mouse_accum.sv ====
`timescale 1ns/100ps

module mouse_accum import input_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        lock,
    mouse_if.sink       mouse,
    output logic [15:0] mouse_1p,
    output logic [15:0] mouse_2p,
    output mouse_but_t  but_1p,
    output mouse_but_t  but_2p
);

    pos_t       pos_x [2];
    pos_t       pos_y [2];
    mouse_but_t but_q [2];
    logic       take;

    assign take = mouse.st && !lock;   // reports dropped while locked

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                pos_x[i] <= '0;
                pos_y[i] <= '0;
                but_q[i] <= '0;
            end
        end else if (take) begin
            // idx picks the player, sums wrap at 8 bits
            pos_x[mouse.idx] <= pos_x[mouse.idx] + mouse.dx[7:0];
            pos_y[mouse.idx] <= pos_y[mouse.idx] + mouse.dy[7:0];
            but_q[mouse.idx] <= mouse.flags[2:0];
        end
    end

    // y in the upper byte
    assign mouse_1p = {pos_y[0], pos_x[0]};
    assign mouse_2p = {pos_y[1], pos_x[1]};

    assign but_1p = lock ? '0 : but_q[0];
    assign but_2p = lock ? '0 : but_q[1];

endmodule

// ==== input_ctrl.sv ====
`timescale 1ns/100ps

module input_ctrl import input_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       vs,
    input  logic       autofire0,
    input  logic       dip_flip,
    input  logic       rot_control,
    input  logic       core_4way,
    input  logic       lock,
    input  logic       downloading,
    input  logic       key_pause,
    input  logic       osd_pause,
    input  logic       key_reset,
    input  logic       key_service,
    input  coin_t      key_coin,
    input  coin_t      key_start,
    input  coin_t      board_coin,
    input  coin_t      board_start,
    input  board_joy_t joy1_raw,
    input  board_joy_t joy2_raw,
    input  logic       joy_pause_raw1,
    input  logic       joy_pause_raw2,
    output logic       en4way,
    output logic       rot,
    output logic       flip,
    output logic       autofire,
    output logic       lock_q,
    output logic       soft_rst,
    output logic       game_pause,
    output logic       game_service,
    output coin_t      game_coin,
    output coin_t      game_start
);

    logic         vs_l, key_pause_l, joy_pause_l, osd_pause_l, key_reset_l, service_l;
    logic         vbl_in, vbl_out;
    logic         joy_pause, pause_toggle, service_rise;
    logic [2:0]   firecnt;
    coin_t        joy_coin, joy_start;
    pause_state_e state, state_n;

    assign vbl_in  = vs && !vs_l;
    assign vbl_out = !vs && vs_l;

    assign joy_pause    = joy_pause_raw1 | joy_pause_raw2;
    assign pause_toggle = (key_pause && !key_pause_l) || (joy_pause && !joy_pause_l);
    assign service_rise = key_service && !service_l;

    assign joy_coin  = {2'b00, joy2_raw[COIN_BIT], joy1_raw[COIN_BIT]};
    assign joy_start = {2'b00, joy2_raw[START_BIT], joy1_raw[START_BIT]};

    assign en4way = core_4way;
    assign rot    = rot_control;
    assign flip   = ~dip_flip;      // dip reads low when flipped

    assign game_pause = (state == paused);

    always_comb begin
        state_n = state;
        case (state)
            run:        if (pause_toggle) state_n = paused;
            paused: begin
                if (pause_toggle) begin
                    state_n = run;
                end else if (service_rise) begin
                    state_n = step_frame;
                end
            end
            step_frame: if (vbl_out) state_n = paused;
            default:    state_n = run;
        endcase
        if (osd_pause != osd_pause_l) begin
            state_n = osd_pause ? paused : run;   // OSD wins over the keys
        end
        if (lock || downloading) begin
            state_n = run;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {vs_l, key_pause_l, joy_pause_l, osd_pause_l, key_reset_l, service_l} <= '0;
            firecnt      <= '0;
            autofire     <= 1'b1;
            lock_q       <= 1'b0;
            soft_rst     <= 1'b0;
            state        <= run;
            game_service <= ACTIVE_LOW;
            game_coin    <= {4{ACTIVE_LOW}};
            game_start   <= {4{ACTIVE_LOW}};
        end else begin
            vs_l        <= vs;
            key_pause_l <= key_pause;
            joy_pause_l <= joy_pause;
            osd_pause_l <= osd_pause;
            key_reset_l <= key_reset;
            service_l   <= key_service;
            if (vbl_in) begin
                firecnt <= firecnt + 3'd1;   // one count per frame
            end
            autofire <= !autofire0 || (firecnt > AUTOFIRE_DIV);
            lock_q   <= lock;
            soft_rst <= key_reset && !key_reset_l;
            state    <= state_n;
            if (lock) begin
                game_service <= ACTIVE_LOW;
                game_coin    <= {4{ACTIVE_LOW}};
                game_start   <= {4{ACTIVE_LOW}};
            end else begin
                game_service <= key_service ^ ACTIVE_LOW;
                game_coin    <= (key_coin | board_coin | joy_coin) ^ {4{ACTIVE_LOW}};
                game_start   <= (key_start | board_start | joy_start) ^ {4{ACTIVE_LOW}};
            end
        end
    end

endmodule

// ==== input_top.sv ====
`timescale 1ns/100ps

module input_top import input_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         vs,
    input  logic         autofire0,
    input  logic         dip_flip,
    input  logic         rot_control,
    input  logic         core_4way,
    input  logic         lock,
    input  logic         downloading,
    input  logic         key_pause,
    input  logic         osd_pause,
    input  logic         key_reset,
    input  logic         key_service,
    input  logic         key_test,
    input  coin_t        key_coin,
    input  coin_t        key_start,
    input  coin_t        board_coin,
    input  coin_t        board_start,
    input  board_joy_t   board_joy1,
    input  board_joy_t   board_joy2,
    input  joy_t         key_joy1,
    input  joy_t         key_joy2,
    input  mouse_delta_t bd_mouse_dx,
    input  mouse_delta_t bd_mouse_dy,
    input  logic [7:0]   bd_mouse_f,
    input  logic         bd_mouse_st,
    input  logic         bd_mouse_idx,
    output joy_t         game_joy1,
    output joy_t         game_joy2,
    output coin_t        game_coin,
    output coin_t        game_start,
    output logic         game_service,
    output logic         game_test,
    output logic         game_pause,
    output logic         soft_rst,
    output logic [15:0]  mouse_1p,
    output logic [15:0]  mouse_2p,
    output pos_t         paddle
);

    logic       en4way, rot, flip, autofire, lock_q;
    logic       joy_pause_raw1, joy_pause_raw2;
    logic [3:0] dir4_1p, dir4_2p;
    mouse_but_t but_1p, but_2p;

    mouse_if mouse_bus ();

    assign mouse_bus.dx    = bd_mouse_dx;
    assign mouse_bus.dy    = bd_mouse_dy;
    assign mouse_bus.flags = bd_mouse_f;
    assign mouse_bus.st    = bd_mouse_st;
    assign mouse_bus.idx   = bd_mouse_idx;

    assign game_test = key_test;

    input_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .vs             (vs),
        .autofire0      (autofire0),
        .dip_flip       (dip_flip),
        .rot_control    (rot_control),
        .core_4way      (core_4way),
        .lock           (lock),
        .downloading    (downloading),
        .key_pause      (key_pause),
        .osd_pause      (osd_pause),
        .key_reset      (key_reset),
        .key_service    (key_service),
        .key_coin       (key_coin),
        .key_start      (key_start),
        .board_coin     (board_coin),
        .board_start    (board_start),
        .joy1_raw       (board_joy1),
        .joy2_raw       (board_joy2),
        .joy_pause_raw1 (joy_pause_raw1),
        .joy_pause_raw2 (joy_pause_raw2),
        .en4way         (en4way),
        .rot            (rot),
        .flip           (flip),
        .autofire       (autofire),
        .lock_q         (lock_q),
        .soft_rst       (soft_rst),
        .game_pause     (game_pause),
        .game_service   (game_service),
        .game_coin      (game_coin),
        .game_start     (game_start)
    );

    four_way_joy four_way_1p_i (
        .clk     (clk),
        .rst     (rst),
        .enable  (en4way),
        .joy8way (board_joy1[3:0]),
        .joy4way (dir4_1p)
    );

    four_way_joy four_way_2p_i (
        .clk     (clk),
        .rst     (rst),
        .enable  (en4way),
        .joy8way (board_joy2[3:0]),
        .joy4way (dir4_2p)
    );

    joy_mapper mapper_1p_i (
        .clk           (clk),
        .rst           (rst),
        .board         (board_joy1),
        .dir4          (dir4_1p),
        .key           (key_joy1),
        .mouse_but     (but_1p),
        .rot           (rot),
        .flip          (flip),
        .autofire      (autofire),
        .lock          (lock_q),
        .joy           (game_joy1),
        .joy_pause_raw (joy_pause_raw1)
    );

    joy_mapper mapper_2p_i (
        .clk           (clk),
        .rst           (rst),
        .board         (board_joy2),
        .dir4          (dir4_2p),
        .key           (key_joy2),
        .mouse_but     (but_2p),
        .rot           (rot),
        .flip          (flip),
        .autofire      (autofire),
        .lock          (lock_q),
        .joy           (game_joy2),
        .joy_pause_raw (joy_pause_raw2)
    );

    paddle_accum paddle_i (
        .clk    (clk),
        .rst    (rst),
        .mouse  (mouse_bus.sink),
        .paddle (paddle)
    );

    mouse_accum mouse_i (
        .clk      (clk),
        .rst      (rst),
        .lock     (lock),
        .mouse    (mouse_bus.sink),
        .mouse_1p (mouse_1p),
        .mouse_2p (mouse_2p),
        .but_1p   (but_1p),
        .but_2p   (but_2p)
    );

endmodule

// ==== input_checker.sv ====
`timescale 1ns/100ps

module input_checker import input_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [2:0]   test_id,
    input  logic         vs,
    input  logic         autofire0,
    input  logic         dip_flip,
    input  logic         rot_control,
    input  logic         core_4way,
    input  logic         lock,
    input  logic         downloading,
    input  logic         key_pause,
    input  logic         osd_pause,
    input  logic         key_reset,
    input  logic         key_service,
    input  logic         key_test,
    input  coin_t        key_coin,
    input  coin_t        key_start,
    input  coin_t        board_coin,
    input  coin_t        board_start,
    input  board_joy_t   board_joy1,
    input  board_joy_t   board_joy2,
    input  joy_t         key_joy1,
    input  joy_t         key_joy2,
    input  mouse_delta_t bd_mouse_dx,
    input  mouse_delta_t bd_mouse_dy,
    input  logic [7:0]   bd_mouse_f,
    input  logic         bd_mouse_st,
    input  logic         bd_mouse_idx,
    input  joy_t         game_joy1,
    input  joy_t         game_joy2,
    input  coin_t        game_coin,
    input  coin_t        game_start,
    input  logic         game_service,
    input  logic         game_test,
    input  logic         game_pause,
    input  logic         soft_rst,
    input  logic [15:0]  mouse_1p,
    input  logic [15:0]  mouse_2p,
    input  pos_t         paddle,
    output int           check_count,
    output int           error_count
);

    logic [2:0]   fcnt;            // vs rising edges modulo 8
    logic [3:0]   last_dir [2];
    logic [3:0]   dir_exp [2];
    pos_t         pos_x [2];
    pos_t         pos_y [2];
    mouse_but_t   but_m [2];
    pos_t         pad;
    pause_state_e pstate;
    logic         kp_p, jp_p, osd_p, svc_p, vs_p, kr_p;
    logic [86:0]  sig, sig_p;      // everything that feeds the settled outputs
    int           stable;
    int           cur_id = 0;
    int           n_checks = 0;
    int           n_errors = 0;
    int           t_checks = 0;
    int           t_errors = 0;

    assign check_count = n_checks;
    assign error_count = n_errors;

    function automatic string test_name(int id);
        case (id)
            1: return "joystick mapping";
            2: return "4-way filter";
            3: return "coins, starts and lock";
            4: return "pause state machine";
            5: return "mouse and paddle";
            6: return "soft reset and autofire";
            default: return "unknown";
        endcase
    endfunction

    // merge, autofire, rotation, polarity, lock
    function automatic joy_t expect_joy(board_joy_t b, logic [3:0] dir, joy_t k,
                                        mouse_but_t mb, logic af);
        joy_t m;
        joy_t r;
        m = {b[9:4], dir} | k | {3'd0, mb, 4'd0};
        r = m;
        r[4] = m[4] & af;
        if (rot_control && !dip_flip) begin
            r[3:0] = {m[1], m[0], m[2], m[3]};   // flip is the inverted dip
        end else if (rot_control) begin
            r[3:0] = {m[0], m[1], m[3], m[2]};
        end
        if (lock) begin
            return {10{ACTIVE_LOW}};
        end
        return r ^ {10{ACTIVE_LOW}};
    endfunction

    task automatic compare(string name, logic [15:0] exp, logic [15:0] act);
        n_checks++;
        t_checks++;
        if (act !== exp) begin
            n_errors++;
            t_errors++;
            $display("FAIL %s: expected %0h, got %0h at %0t ns", name, exp, act, $time);
        end
    endtask

    task automatic close_test(int id);
        if (t_checks == 0) begin
            $display("no checks ran during test %0d", id);
            n_errors++;
        end
        $display("test %0d %s: %0d checks, %0d errors", id, test_name(id), t_checks, t_errors);
        t_checks = 0;
        t_errors = 0;
    endtask

    always @(posedge clk) begin
        logic       jp;
        logic       toggle;
        logic       af;
        logic [3:0] d;
        #2;   // outputs settled and inputs still as sampled
        if (rst) begin
            fcnt   = '0;
            pad    = '0;
            pstate = run;
            stable = 0;
            sig_p  = '0;
            {kp_p, jp_p, osd_p, svc_p, vs_p, kr_p} = '0;
            for (int i = 0; i < 2; i++) begin
                last_dir[i] = '0;
                pos_x[i]    = '0;
                pos_y[i]    = '0;
                but_m[i]    = '0;
            end
        end else begin
            if (vs && !vs_p) begin
                fcnt = fcnt + 3'd1;
            end
            if (bd_mouse_st) begin
                pad = pad + bd_mouse_dx[7:0];   // paddle ignores lock and idx
                if (!lock) begin
                    pos_x[bd_mouse_idx] = pos_x[bd_mouse_idx] + bd_mouse_dx[7:0];
                    pos_y[bd_mouse_idx] = pos_y[bd_mouse_idx] + bd_mouse_dy[7:0];
                    but_m[bd_mouse_idx] = bd_mouse_f[2:0];
                end
            end
            for (int p = 0; p < 2; p++) begin
                d = (p == 0) ? board_joy1[3:0] : board_joy2[3:0];
                dir_exp[p] = d;
                if (core_4way && d != 4'd0) begin
                    if ($countones(d) == 1) begin
                        last_dir[p] = d;
                    end
                    dir_exp[p] = last_dir[p];   // diagonal keeps the last single one
                end
            end

            jp = board_joy1[PAUSE_BIT] | key_joy1[PAUSE_BIT]
               | board_joy2[PAUSE_BIT] | key_joy2[PAUSE_BIT];
            toggle = (key_pause && !kp_p) || (jp && !jp_p);
            case (pstate)
                run: begin
                    if (toggle) pstate = paused;
                end
                paused: begin
                    if (toggle) begin
                        pstate = run;
                    end else if (key_service && !svc_p) begin
                        pstate = step_frame;
                    end
                end
                step_frame: begin
                    if (!vs && vs_p) pstate = paused;
                end
                default: pstate = run;
            endcase
            if (osd_pause != osd_p) begin
                pstate = osd_pause ? paused : run;
            end
            if (lock || downloading) begin
                pstate = run;
            end

            sig = {board_joy1, board_joy2, key_joy1, key_joy2, key_coin, key_start,
                   board_coin, board_start, fcnt, but_m[0], but_m[1], vs, autofire0,
                   dip_flip, rot_control, core_4way, lock, downloading, key_pause,
                   osd_pause, key_service};
            stable = (sig == sig_p) ? stable + 1 : 0;
            sig_p  = sig;

            if (test_id != cur_id) begin
                if (cur_id != 0) begin
                    close_test(cur_id);
                end
                cur_id = test_id;
            end

            if (test_id >= 1 && test_id <= 6) begin
                compare("soft_rst", key_reset && !kr_p, soft_rst);
                compare("game_test", key_test, game_test);
                compare("mouse_1p", {pos_y[0], pos_x[0]}, mouse_1p);
                compare("mouse_2p", {pos_y[1], pos_x[1]}, mouse_2p);
                compare("paddle", pad, paddle);
                if (stable >= 2) begin   // two register stages behind the inputs
                    af = !autofire0 || (fcnt > AUTOFIRE_DIV);
                    compare("game_joy1", expect_joy(board_joy1, dir_exp[0], key_joy1,
                            lock ? '0 : but_m[0], af), game_joy1);
                    compare("game_joy2", expect_joy(board_joy2, dir_exp[1], key_joy2,
                            lock ? '0 : but_m[1], af), game_joy2);
                    compare("game_coin", lock ? {4{ACTIVE_LOW}} : (key_coin | board_coin
                            | {2'b00, board_joy2[COIN_BIT], board_joy1[COIN_BIT]})
                            ^ {4{ACTIVE_LOW}}, game_coin);
                    compare("game_start", lock ? {4{ACTIVE_LOW}} : (key_start | board_start
                            | {2'b00, board_joy2[START_BIT], board_joy1[START_BIT]})
                            ^ {4{ACTIVE_LOW}}, game_start);
                    compare("game_service", lock ? ACTIVE_LOW : key_service ^ ACTIVE_LOW,
                            game_service);
                    compare("game_pause", pstate == paused, game_pause);
                end
            end

            kp_p  = key_pause;
            jp_p  = jp;
            osd_p = osd_pause;
            svc_p = key_service;
            vs_p  = vs;
            kr_p  = key_reset;
        end
    end

endmodule

// ==== tb_input_top.sv ====
`timescale 1ns/100ps

module tb_input_top import input_pkg::*; ();

    localparam int CLK_NS          = 8;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 1000;   // longest test is about 800 cycles
    localparam int MARGIN_NS       = 2000;
    localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_NS + MARGIN_NS;

    logic         clk = 1'b0;
    logic         rst;
    logic         vs, autofire0, dip_flip, rot_control, core_4way, lock, downloading;
    logic         key_pause, osd_pause, key_reset, key_service, key_test;
    coin_t        key_coin, key_start, board_coin, board_start;
    board_joy_t   board_joy1, board_joy2;
    joy_t         key_joy1, key_joy2;
    mouse_delta_t bd_mouse_dx, bd_mouse_dy;
    logic [7:0]   bd_mouse_f;
    logic         bd_mouse_st, bd_mouse_idx;
    joy_t         game_joy1, game_joy2;
    coin_t        game_coin, game_start;
    logic         game_service, game_test, game_pause, soft_rst;
    logic [15:0]  mouse_1p, mouse_2p;
    pos_t         paddle;
    logic [2:0]   test_id;
    int           check_count;
    int           error_count;
    logic [31:0]  seed = 32'haeccd012;
    logic [31:0]  r;

    // singles first, then the four diagonals
    logic [3:0] dir_table [8] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'h6, 4'h9, 4'ha};

    always #(CLK_NS / 2) clk = ~clk;

    input_top dut_i (.*);

    input_checker checker_i (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic hold(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic random_joys(logic [15:0] board_mask, logic [9:0] key_mask);
        r = next_rand();
        board_joy1 = r[31:16] & board_mask;
        r = next_rand();
        board_joy2 = r[31:16] & board_mask;
        r = next_rand();
        key_joy1 = r[31:22] & key_mask;
        r = next_rand();
        key_joy2 = r[31:22] & key_mask;
    endtask

    // one mouse report, takes one cycle
    task automatic pulse_strobe();
        r = next_rand();
        bd_mouse_dx = r[31:23];
        bd_mouse_dy = r[22:14];
        r = next_rand();
        bd_mouse_f   = r[31:24];
        bd_mouse_idx = r[23];
        bd_mouse_st  = 1'b1;
        hold(1);
        bd_mouse_st  = 1'b0;
    endtask

    initial begin
        {vs, autofire0, dip_flip, rot_control, core_4way, lock, downloading} = '0;
        {key_pause, osd_pause, key_reset, key_service, key_test} = '0;
        {key_coin, key_start, board_coin, board_start} = '0;
        {board_joy1, board_joy2, key_joy1, key_joy2} = '0;
        {bd_mouse_dx, bd_mouse_dy, bd_mouse_f, bd_mouse_st, bd_mouse_idx} = '0;
        test_id = 3'd0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        hold(4);

        test_id = 3'd1;   // autofire0 low keeps fire open
        for (int i = 0; i < 150; i++) begin
            random_joys(16'hffff, 10'h3ff);
            r = next_rand();
            rot_control = r[31];
            dip_flip    = r[30];
            pulse_strobe();
            hold(3);
        end

        test_id = 3'd2;
        {core_4way, rot_control, key_joy1, key_joy2} = {1'b1, 1'b0, 20'd0};
        for (int i = 0; i < 150; i++) begin
            r = next_rand();
            board_joy1 = {r[31:20], dir_table[r[19:17]]};
            r = next_rand();
            board_joy2 = {r[31:20], dir_table[r[19:17]]};
            hold(4);
        end

        test_id = 3'd3;
        core_4way = 1'b0;
        for (int i = 0; i < 100; i++) begin
            random_joys(16'hfeff, 10'h000);   // no joystick pause next to osd changes
            r = next_rand();
            {key_coin, key_start, board_coin, board_start} = r[31:16];
            r = next_rand();
            key_service = r[31];
            key_test    = r[30];
            osd_pause   = r[29];
            lock        = (r[28:27] == 2'b00);
            hold(4);
        end

        test_id = 3'd4;   // one pause input changes per window
        lock = 1'b0;
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            case (r[31:28])
                0, 1:        key_pause = !key_pause;
                2:           board_joy1[PAUSE_BIT] = !board_joy1[PAUSE_BIT];
                3:           key_joy2[PAUSE_BIT] = !key_joy2[PAUSE_BIT];
                4:           osd_pause = !osd_pause;
                5, 6, 7:     key_service = !key_service;
                8, 9, 10, 11: vs = !vs;
                default:     downloading = (r[27:26] == 2'b00);
            endcase
            hold(4);
        end

        test_id = 3'd5;
        downloading = 1'b0;
        {board_joy1, board_joy2, key_joy1, key_joy2} = '0;
        for (int i = 0; i < 300; i++) begin
            lock = (i % 64) >= 48;
            r = next_rand();
            if (r[31]) begin
                pulse_strobe();
            end else begin
                hold(1);
            end
        end

        test_id = 3'd6;
        lock = 1'b0;
        for (int i = 0; i < 40; i++) begin
            key_reset = 1'b1;
            r = next_rand();
            hold(1 + r[31:30]);
            key_reset = 1'b0;
            r = next_rand();
            hold(1 + r[31:30]);
        end
        // fire held on both sticks, gated by the frame counter
        {autofire0, rot_control, core_4way} = 3'b100;
        board_joy1 = 16'h0010;
        board_joy2 = 16'h0010;
        for (int i = 0; i < 20; i++) begin
            vs = 1'b1;
            hold(4);
            vs = 1'b0;
            hold(4);
        end

        test_id = 3'd7;
        hold(2);
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

// ==== flist.f ====
input_pkg.sv
mouse_if.sv
four_way_joy.sv
joy_mapper.sv
paddle_accum.sv
mouse_accum.sv
input_ctrl.sv
input_top.sv
input_checker.sv
tb_input_top.sv

// ==== Bender.yml ====
package:
  name: input_block

sources:
  - input_pkg.sv
  - mouse_if.sv
  - four_way_joy.sv
  - joy_mapper.sv
  - paddle_accum.sv
  - mouse_accum.sv
  - input_ctrl.sv
  - input_top.sv
  - target: test
    files:
      - input_checker.sv
      - tb_input_top.sv
